//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= lsuTb
FILELIST ?= vlog.f
OBJDIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJDIR)

//--- include/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// bus and register tag widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_REG_W 5

// kseg1 style base subtracted from every virtual address
`define LSU_SEG_BASE 32'ha0000000

// entries in the request and response queues
`define LSU_QUEUE_DEPTH 4

`endif

//--- sim/lsuTb.sv
`default_nettype none
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsuTb;
	import lsuPkg::*;

	logic clk;
	logic arstN;
	logic reqValid;
	logic reqReady;
	accessOp_t reqOp;
	logic [31:0] reqVAddr;
	logic [31:0] reqWData;
	logic [4:0] reqRd;
	logic rspValid;
	logic rspReady;
	logic [4:0] rspRd;
	logic [31:0] rspData;
	excCode_t rspExc;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [31:0] wbAdr;
	logic [31:0] wbDatO;
	logic [3:0] wbSel;
	logic [31:0] wbDatI;
	logic wbAck;

	accessOp_t caseOp [$];
	logic [31:0] caseAddr [$];
	logic [31:0] caseWData [$];
	logic [4:0] caseRd [$];
	logic [31:0] caseData [$];
	excCode_t caseExc [$];
	// {we, sel, adr, dat} of every finished bus cycle
	logic [68:0] busLog [$];
	logic [31:0] mem [logic [29:0]];
	int numCases;
	int rspIdx;
	int passCount;
	int failCount;
	bit loaded;

	lsuTop lsuTop_inst (.*);

	always #5 clk = ~clk;

	// one lane at a time from the store width and the byte offset
	function automatic logic [3:0] laneSel(accessOp_t op, logic [31:0] pAddr);
		logic [3:0] s;
		for (int i = 0; i < 4; i++) begin
			case (op)
				SB: s[i] = (i == int'(pAddr[1:0]));
				SH: s[i] = ((i / 2) == int'(pAddr[1]));
				default: s[i] = 1'b1;
			endcase
		end
		return s;
	endfunction

	function automatic logic [31:0] laneData(accessOp_t op, logic [31:0] w);
		logic [31:0] d;
		for (int i = 0; i < 4; i++) begin
			case (op)
				SB: d[i*8 +: 8] = w[7:0];
				SH: d[i*8 +: 8] = (i % 2 == 0) ? w[7:0] : w[15:8];
				default: d[i*8 +: 8] = w[i*8 +: 8];
			endcase
		end
		return d;
	endfunction

	function automatic logic [31:0] readWord(logic [29:0] wordAddr);
		if (mem.exists(wordAddr)) begin
			return mem[wordAddr];
		end
		// untouched words hold a pattern of their own address
		return {wordAddr[15:0], ~wordAddr[29:14]};
	endfunction

	task automatic readCases();
		int fd;
		int got;
		string line;
		logic [31:0] kindF;
		logic [31:0] addrF;
		logic [31:0] wDataF;
		logic [31:0] rdF;
		logic [31:0] dataF;
		logic [31:0] excF;
		fd = $fopen("sim/lsu_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/lsu_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				got = $fgets(line, fd);
				// header lines do not scan as six hex fields
				if (got > 0 && $sscanf(line, "%h %h %h %h %h %h",
						kindF, addrF, wDataF, rdF, dataF, excF) == 6) begin
					caseOp.push_back(accessOp_t'(kindF[2:0]));
					caseAddr.push_back(addrF);
					caseWData.push_back(wDataF);
					caseRd.push_back(rdF[4:0]);
					caseData.push_back(dataF);
					caseExc.push_back(excCode_t'(excF[4:0]));
				end
			end
			$fclose(fd);
		end
		numCases = caseOp.size();
	endtask

	task automatic sendRequests();
		for (int n = 0; n < numCases; n++) begin
			reqValid = 1'b1;
			reqOp = caseOp[n];
			reqVAddr = caseAddr[n];
			reqWData = caseWData[n];
			reqRd = caseRd[n];
			@(posedge clk);
			while (!reqReady) begin
				@(posedge clk);
			end
			#1;
		end
		reqValid = 1'b0;
	endtask

	task automatic checkResponse(int n);
		int errs;
		logic [68:0] entry;
		logic [31:0] pAddr;
		logic isStore;
		errs = 0;
		assert (n < numCases) else begin
			$display("unexpected response with rd %h after the last case", rspRd);
			failCount++;
		end
		if (n >= numCases) begin
			return;
		end
		isStore = caseOp[n] inside {SB, SH, SW};
		pAddr = caseAddr[n] - `LSU_SEG_BASE;
		assert (rspRd == caseRd[n]) else begin
			$display("FAIL case %0d rspRd: got %h expected %h", n, rspRd, caseRd[n]);
			errs++;
		end
		assert (rspData == caseData[n]) else begin
			$display("FAIL case %0d rspData: got %h expected %h", n, rspData, caseData[n]);
			errs++;
		end
		assert (rspExc == caseExc[n]) else begin
			$display("FAIL case %0d rspExc: got %h expected %h", n, rspExc, caseExc[n]);
			errs++;
		end
		if (caseExc[n] == NONE) begin
			assert (busLog.size() != 0) else begin
				$display("case %0d answered without a bus cycle", n);
				errs++;
			end
			if (busLog.size() != 0) begin
				entry = busLog.pop_front();
				assert (entry[68] == isStore) else begin
					$display("FAIL case %0d wbWe: got %h expected %h", n, entry[68], isStore);
					errs++;
				end
				assert (entry[67:64] == laneSel(caseOp[n], pAddr)) else begin
					$display("FAIL case %0d wbSel: got %h expected %h", n, entry[67:64],
						laneSel(caseOp[n], pAddr));
					errs++;
				end
				assert (entry[63:32] == {pAddr[31:2], 2'b00}) else begin
					$display("FAIL case %0d wbAdr: got %h expected %h", n, entry[63:32],
						{pAddr[31:2], 2'b00});
					errs++;
				end
				assert (!isStore || entry[31:0] == laneData(caseOp[n], caseWData[n])) else begin
					$display("FAIL case %0d wbDatO: got %h expected %h", n, entry[31:0],
						laneData(caseOp[n], caseWData[n]));
					errs++;
				end
			end
		end
		if (errs == 0) begin
			$display("case %0d %s rd %h: ok", n, caseOp[n].name(), caseRd[n]);
			passCount++;
		end else begin
			$display("case %0d %s rd %h: %0d mismatches", n, caseOp[n].name(), caseRd[n], errs);
			failCount++;
		end
	endtask

	// wishbone slave with 0 to 3 wait cycles per access
	always begin
		int waitCycles;
		logic [29:0] wordAddr;
		logic [31:0] mask;
		@(posedge clk);
		if (arstN && wbCyc && wbStb) begin
			waitCycles = int'($urandom % 4);
			repeat (waitCycles) @(posedge clk);
			#1;
			wordAddr = wbAdr[31:2];
			mask = {{8{wbSel[3]}}, {8{wbSel[2]}}, {8{wbSel[1]}}, {8{wbSel[0]}}};
			busLog.push_back({wbWe, wbSel, wbAdr, wbDatO});
			if (wbWe) begin
				mem[wordAddr] = (readWord(wordAddr) & ~mask) | (wbDatO & mask);
			end
			wbDatI = readWord(wordAddr);
			wbAck = 1'b1;
			@(posedge clk);
			#1;
			wbAck = 1'b0;
		end
	end

	always @(posedge clk) begin
		#1;
		if (arstN) begin
			rspReady = ($urandom % 4) != 0;
		end
	end

	always @(posedge clk) begin
		if (arstN && rspValid && rspReady) begin
			checkResponse(rspIdx);
			rspIdx++;
		end
	end

	initial begin
		wait (loaded);
		repeat (numCases * 60 + 16) @(posedge clk);
		$display("timeout with %0d of %0d responses seen", rspIdx, numCases);
		$display("Test failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		reqValid = 1'b0;
		reqOp = LB;
		reqVAddr = '0;
		reqWData = '0;
		reqRd = '0;
		rspReady = 1'b0;
		wbDatI = '0;
		wbAck = 1'b0;
		rspIdx = 0;
		passCount = 0;
		failCount = 0;
		void'($urandom(32'hb1a49d82));
		readCases();
		if (numCases == 0) begin
			$display("no cases read from the case file");
			failCount++;
		end
		loaded = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		arstN = 1'b1;
		@(posedge clk);
		assert (!wbCyc && !wbStb && !rspValid && reqReady) else begin
			$display("FAIL reset wbCyc %h wbStb %h rspValid %h reqReady %h",
				wbCyc, wbStb, rspValid, reqReady);
			failCount++;
		end
		$display("reset state checked");
		#1;
		sendRequests();
		wait (rspIdx >= numCases);
		repeat (8) @(posedge clk);
		assert (busLog.size() == 0) else begin
			$display("%0d bus cycles had no matching response", busLog.size());
			failCount++;
		end
		$display("cases passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/lsu_cases.txt
// kind (0 lb, 1 lbu, 2 lh, 3 lhu, 4 lw, 5 sb, 6 sh, 7 sw), vaddr, wdata, rd,
// expected rsp data, expected exc (0 none, 4 adel, 5 ades), all hex
7 a0000010 12345678 01 00000000 00
4 a0000010 00000000 02 12345678 00
5 a0000021 000000c3 03 00000000 00
6 a0000022 ffff8a5b 04 00000000 00
0 a0000021 00000000 05 ffffffc3 00
1 a0000021 00000000 06 000000c3 00
2 a0000022 00000000 07 ffff8a5b 00
3 a0000022 00000000 08 00008a5b 00
5 a0000030 0000007f 09 00000000 00
0 a0000030 00000000 0a 0000007f 00
2 a0000011 00000000 0b a0000011 04
4 a0000012 00000000 0c a0000012 04
6 a0000023 00000000 0d a0000023 05
7 a0000016 00000000 0e a0000016 05
7 a0000040 deadbeef 0f 00000000 00
2 a0000040 00000000 10 ffffbeef 00

//--- src/accessDecode.sv
`default_nettype none
`timescale 1ns/10ps

`include "lsu_defs.svh"

module accessDecode (
	input  lsuPkg::accessOp_t       op,
	input  logic [`LSU_ADDR_W-1:0]  vAddr,
	input  logic [`LSU_DATA_W-1:0]  wData,
	input  logic [`LSU_REG_W-1:0]   rd,
	output lsuPkg::memReq_t         req
);
	import lsuPkg::*;

	logic [`LSU_ADDR_W-1:0] pAddr;
	logic isStore;
	logic misaligned;
	logic [3:0] sel;

	always_comb begin
		pAddr = vAddr - `LSU_SEG_BASE;
		isStore = op inside {SB, SH, SW};
		case (op)
			LH, LHU, SH: misaligned = vAddr[0];
			LW, SW: misaligned = |vAddr[1:0];
			default: misaligned = 1'b0;
		endcase

		// byte lanes
		case (op)
			SB: sel = 4'b0001 << pAddr[1:0];
			SH: sel = pAddr[1] ? 4'b1100 : 4'b0011;
			default: sel = 4'b1111;
		endcase
		if (misaligned) begin
			sel = 4'b0000;
		end
	end

	always_comb begin
		req.op = op;
		req.rd = rd;
		req.sel = sel;
		req.addr = misaligned ? vAddr : pAddr;
		if (misaligned) begin
			req.exc = isStore ? ADES : ADEL;
		end else begin
			req.exc = NONE;
		end
		// replicate narrow store data over all lanes
		case (op)
			SB: req.wData = {4{wData[7:0]}};
			SH: req.wData = {2{wData[15:0]}};
			default: req.wData = wData;
		endcase
	end

endmodule

`default_nettype wire

//--- src/accessQueue.sv
`default_nettype none
`timescale 1ns/10ps

`include "lsu_defs.svh"

module accessQueue #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  T     inData,
	output logic inReady,
	output logic outValid,
	input  logic outReady,
	output T     outData
);
	localparam int PtrW = $clog2(`LSU_QUEUE_DEPTH);
	localparam logic [PtrW:0] Depth = (PtrW + 1)'(`LSU_QUEUE_DEPTH);
	localparam logic [PtrW-1:0] LastIdx = PtrW'(`LSU_QUEUE_DEPTH - 1);

	T mem [`LSU_QUEUE_DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0] count;
	logic push;
	logic pop;

	assign inReady = (count != Depth);
	assign outValid = (count != '0);
	assign push = inValid && inReady;
	assign pop = outValid && outReady;
	assign outData = mem[rdPtr];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == LastIdx) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == LastIdx) ? '0 : rdPtr + 1'b1;
			end
			count <= count + (PtrW + 1)'(push) - (PtrW + 1)'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= inData;
		end
	end

	assert property (@(posedge clk) disable iff (!arstN) count <= Depth)
		else $error("queue count %0d above depth", count);

endmodule

`default_nettype wire

//--- src/loadAlign.sv
`default_nettype none
`timescale 1ns/10ps

`include "lsu_defs.svh"

module loadAlign (
	input  lsuPkg::memReq_t    raw,
	output lsuPkg::accessRsp_t rsp
);
	import lsuPkg::*;

	logic [`LSU_DATA_W-1:0] shifted;

	always_comb begin
		// addressed lane moved down to bit 0
		shifted = raw.wData >> {raw.addr[1:0], 3'b000};
		rsp.rd = raw.rd;
		rsp.exc = raw.exc;
		if (raw.exc != NONE) begin
			rsp.data = raw.addr;
		end else begin
			case (raw.op)
				LB: rsp.data = {{24{shifted[7]}}, shifted[7:0]};
				LBU: rsp.data = {24'h000000, shifted[7:0]};
				LH: rsp.data = {{16{shifted[15]}}, shifted[15:0]};
				LHU: rsp.data = {16'h0000, shifted[15:0]};
				LW: rsp.data = raw.wData;
				// stores return nothing
				default: rsp.data = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/lsuPkg.sv
`default_nettype none

`include "lsu_defs.svh"

package lsuPkg;

	// memory access kinds handled by the unit
	typedef enum logic [2:0] {
		LB,
		LBU,
		LH,
		LHU,
		LW,
		SB,
		SH,
		SW
	} accessOp_t;

	// MIPS cause codes for address errors
	typedef enum logic [4:0] {
		NONE = 5'd0,
		ADEL = 5'd4,
		ADES = 5'd5
	} excCode_t;

	typedef struct packed {
		accessOp_t op;
		// virtual address when exc is set
		logic [`LSU_ADDR_W-1:0] addr;
		logic [3:0] sel;
		logic [`LSU_DATA_W-1:0] wData;
		logic [`LSU_REG_W-1:0] rd;
		excCode_t exc;
	} memReq_t;

	typedef struct packed {
		logic [`LSU_REG_W-1:0] rd;
		logic [`LSU_DATA_W-1:0] data;
		excCode_t exc;
	} accessRsp_t;

endpackage

`default_nettype wire

//--- src/lsuTop.sv
`default_nettype none
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsuTop (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   reqValid,
	output logic                   reqReady,
	input  lsuPkg::accessOp_t      reqOp,
	input  logic [`LSU_ADDR_W-1:0] reqVAddr,
	input  logic [`LSU_DATA_W-1:0] reqWData,
	input  logic [`LSU_REG_W-1:0]  reqRd,
	output logic                   rspValid,
	input  logic                   rspReady,
	output logic [`LSU_REG_W-1:0]  rspRd,
	output logic [`LSU_DATA_W-1:0] rspData,
	output lsuPkg::excCode_t       rspExc,
	output logic                   wbCyc,
	output logic                   wbStb,
	output logic                   wbWe,
	output logic [`LSU_ADDR_W-1:0] wbAdr,
	output logic [`LSU_DATA_W-1:0] wbDatO,
	output logic [3:0]             wbSel,
	input  logic [`LSU_DATA_W-1:0] wbDatI,
	input  logic                   wbAck
);
	import lsuPkg::*;

	memReq_t decReq;
	memReq_t qReq;
	logic qReqValid;
	logic qReqReady;
	memReq_t rawRsp;
	logic rawValid;
	logic rawReady;
	accessRsp_t alignedRsp;
	accessRsp_t rspOut;

	accessDecode accessDecode_inst (
		.op    (reqOp),
		.vAddr (reqVAddr),
		.wData (reqWData),
		.rd    (reqRd),
		.req   (decReq)
	);

	accessQueue #(.T(memReq_t)) reqQueue_inst (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (reqValid),
		.inData   (decReq),
		.inReady  (reqReady),
		.outValid (qReqValid),
		.outReady (qReqReady),
		.outData  (qReq)
	);

	wbMaster wbMaster_inst (
		.clk      (clk),
		.arstN    (arstN),
		.reqValid (qReqValid),
		.req      (qReq),
		.reqReady (qReqReady),
		.rspValid (rawValid),
		.rspReady (rawReady),
		.rspRaw   (rawRsp),
		.wbCyc    (wbCyc),
		.wbStb    (wbStb),
		.wbWe     (wbWe),
		.wbAdr    (wbAdr),
		.wbDatO   (wbDatO),
		.wbSel    (wbSel),
		.wbDatI   (wbDatI),
		.wbAck    (wbAck)
	);

	loadAlign loadAlign_inst (
		.raw (rawRsp),
		.rsp (alignedRsp)
	);

	accessQueue #(.T(accessRsp_t)) rspQueue_inst (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (rawValid),
		.inData   (alignedRsp),
		.inReady  (rawReady),
		.outValid (rspValid),
		.outReady (rspReady),
		.outData  (rspOut)
	);

	assign rspRd = rspOut.rd;
	assign rspData = rspOut.data;
	assign rspExc = rspOut.exc;

endmodule

`default_nettype wire

//--- src/wbMaster.sv
`default_nettype none
`timescale 1ns/10ps

`include "lsu_defs.svh"

module wbMaster (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   reqValid,
	input  lsuPkg::memReq_t        req,
	output logic                   reqReady,
	output logic                   rspValid,
	input  logic                   rspReady,
	output lsuPkg::memReq_t        rspRaw,
	output logic                   wbCyc,
	output logic                   wbStb,
	output logic                   wbWe,
	output logic [`LSU_ADDR_W-1:0] wbAdr,
	output logic [`LSU_DATA_W-1:0] wbDatO,
	output logic [3:0]             wbSel,
	input  logic [`LSU_DATA_W-1:0] wbDatI,
	input  logic                   wbAck
);
	import lsuPkg::*;

	typedef enum logic [1:0] {
		IDLE,
		BUS,
		HOLD
	} state_t;

	state_t state;
	memReq_t cur;

	assign reqReady = (state == IDLE);
	assign rspValid = (state == HOLD);
	assign rspRaw = cur;

	// bus outputs come straight from the held request
	assign wbCyc = (state == BUS);
	assign wbStb = (state == BUS);
	assign wbWe = (state == BUS) && (cur.op inside {SB, SH, SW});
	assign wbAdr = {cur.addr[`LSU_ADDR_W-1:2], 2'b00};
	assign wbDatO = cur.wData;
	assign wbSel = cur.sel;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (reqValid) begin
						// address errors never reach the bus
						state <= (req.exc != NONE) ? HOLD : BUS;
					end
				end
				BUS: begin
					if (wbAck) begin
						state <= HOLD;
					end
				end
				HOLD: begin
					if (rspReady) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reqValid && reqReady) begin
			cur <= req;
		end else if (state == BUS && wbAck) begin
			cur.wData <= wbDatI;
		end
	end

	// address and strobe held until ack in a classic cycle
	assert property (@(posedge clk) disable iff (!arstN)
		wbStb && !wbAck |=> wbStb && $stable(wbAdr) && $stable(wbSel))
		else $error("bus signals changed before ack");

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
src/lsuPkg.sv
src/accessDecode.sv
src/accessQueue.sv
src/wbMaster.sv
src/loadAlign.sv
src/lsuTop.sv
sim/lsuTb.sv
